/* run.sh */
#!/bin/sh
# builds the console testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_text_console -f sim.f -o tb_text_console
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_text_console > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" "$log"; then
	exit 1
fi
exit 0

/* sim.f */
src/console_pkg.sv
src/vga_timing.sv
src/cursor_fsm.sv
src/text_ram.sv
src/glyph_ram.sv
src/glyph_render.sv
src/text_console.sv
tests/tb_clock.sv
tests/tb_text_console.sv

/* src/console_pkg.sv */
`default_nettype none

package console_pkg;

	// text grid
	localparam int text_cols = 70;
	localparam int text_rows = 30;
	localparam int text_cells = text_cols * text_rows;

	// character cell in pixels
	localparam int glyph_w = 9;
	localparam int glyph_h = 16;

	// horizontal timing in pixels
	localparam int h_visible = 640;
	localparam int h_front = 16;
	localparam int h_sync = 96;
	localparam int h_back = 48;
	localparam int h_total = h_visible + h_front + h_sync + h_back;

	// vertical timing in lines
	localparam int v_visible = 480;
	localparam int v_front = 10;
	localparam int v_sync = 2;
	localparam int v_back = 33;
	localparam int v_total = v_visible + v_front + v_sync + v_back;

	// code written by the clear sweep and by backspace
	localparam logic [7:0] char_space = 8'h20;

	typedef logic [11:0] cell_addr_t;
	typedef logic [7:0] char_t;
	// bit 0 is the leftmost pixel
	typedef logic [8:0] glyph_row_t;

	typedef enum logic [7:0] {
		cmd_print = 8'h00,
		cmd_backspace = 8'h08,
		cmd_newline = 8'h0A,
		cmd_formfeed = 8'h0C
	} cmd_e;

	typedef enum logic [1:0] {
		st_clear,
		st_idle,
		st_write,
		st_advance
	} cursor_state_e;

	typedef struct packed {
		logic en;
		cell_addr_t addr;
		char_t code;
	} text_wr_t;

	typedef struct packed {
		logic en;
		char_t code;
		logic [3:0] row;
		glyph_row_t bits;
	} glyph_wr_t;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic visible;
		logic hsync;
		logic vsync;
	} scan_pos_t;

endpackage

`default_nettype wire

/* src/cursor_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

module cursor_fsm (
	input wire clk,
	input wire arst_n,
	input wire char_strobe,
	input wire console_pkg::char_t char_code,
	output logic busy,
	output console_pkg::text_wr_t text_wr
);

	import console_pkg::*;

	cursor_state_e state;
	cmd_e cmd;
	cmd_e cmd_q;
	char_t code_q;
	logic [6:0] col;
	logic [4:0] row;
	cell_addr_t sweep;
	cell_addr_t cur_addr;
	logic accept;

	assign busy = (state != st_idle);
	assign accept = char_strobe && !busy;
	assign cur_addr = cell_addr_t'(row * text_cols + col);

	// classify the incoming code
	always_comb begin
		case (char_code)
			8'h0A: cmd = cmd_newline;
			8'h08: cmd = cmd_backspace;
			8'h0C: cmd = cmd_formfeed;
			default: cmd = cmd_print;
		endcase
	end

	always_comb begin
		text_wr = '0;
		if (state == st_clear) begin
			text_wr = '{en: 1'b1, addr: sweep, code: char_space};
		end else if (state == st_write) begin
			text_wr = '{en: 1'b1, addr: cur_addr, code: code_q};
		end
	end

	// payload only, the state decides when it is used
	always_ff @(posedge clk) begin
		if (accept) begin
			code_q <= (cmd == cmd_backspace) ? char_space : char_code;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_clear;
			cmd_q <= cmd_print;
			col <= '0;
			row <= '0;
			sweep <= '0;
		end else begin
			case (state)
				st_clear: begin
					if (sweep == cell_addr_t'(text_cells - 1)) begin
						state <= st_idle;
						col <= '0;
						row <= '0;
					end
					sweep <= sweep + 12'd1;
				end
				st_idle: begin
					if (accept) begin
						cmd_q <= cmd;
						case (cmd)
							cmd_formfeed: begin
								state <= st_clear;
								sweep <= '0;
							end
							cmd_newline: state <= st_advance;
							cmd_backspace: begin
								state <= st_write;
								// step back, wrapping to the end of the row above
								if (col != 7'd0) begin
									col <= col - 7'd1;
								end else if (row != 5'd0) begin
									col <= 7'(text_cols - 1);
									row <= row - 5'd1;
								end
							end
							default: state <= st_write;
						endcase
					end
				end
				st_write: begin
					state <= st_idle;
					if (cmd_q == cmd_print) begin
						if (col != 7'(text_cols - 1)) begin
							col <= col + 7'd1;
						end else if (row != 5'(text_rows - 1)) begin
							col <= '0;
							row <= row + 5'd1;
						end else begin
							// past the last row the screen is cleared
							state <= st_clear;
							sweep <= '0;
						end
					end
				end
				st_advance: begin
					state <= st_idle;
					col <= '0;
					if (row != 5'(text_rows - 1)) begin
						row <= row + 5'd1;
					end else begin
						state <= st_clear;
						sweep <= '0;
					end
				end
				default: state <= st_clear;
			endcase
		end
	end

	a_cursor_in_grid: assert property (
		@(posedge clk) disable iff (!arst_n)
		(col < 7'(text_cols)) && (row < 5'(text_rows))
	);

endmodule

`default_nettype wire

/* src/glyph_ram.sv */
`default_nettype none
`timescale 1ns/1ps

module glyph_ram (
	input wire clk,
	input wire console_pkg::glyph_wr_t glyph_wr,
	input wire console_pkg::char_t rd_code,
	input wire [3:0] rd_row,
	output console_pkg::glyph_row_t rd_bits
);

	import console_pkg::*;

	// 256 codes of glyph_h rows each
	glyph_row_t mem [256 * glyph_h];

	logic [11:0] wr_index;
	logic [11:0] rd_index;

	// code selects the glyph, row the line inside it
	assign wr_index = {glyph_wr.code, glyph_wr.row};
	assign rd_index = {rd_code, rd_row};

	always_ff @(posedge clk) begin
		if (glyph_wr.en) begin
			mem[wr_index] <= glyph_wr.bits;
		end
	end

	always_ff @(posedge clk) begin
		rd_bits <= mem[rd_index];
	end

endmodule

`default_nettype wire

/* src/glyph_render.sv */
`default_nettype none
`timescale 1ns/1ps

module glyph_render (
	input wire clk,
	input wire arst_n,
	input wire console_pkg::scan_pos_t scan,
	output console_pkg::cell_addr_t text_addr,
	input wire console_pkg::char_t text_code,
	output console_pkg::char_t glyph_code,
	output logic [3:0] glyph_row,
	input wire console_pkg::glyph_row_t glyph_bits,
	output logic vga_hsync,
	output logic vga_vsync,
	output logic vga_blank_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);

	import console_pkg::*;

	logic [6:0] cell_col;
	logic [5:0] cell_row;
	logic in_grid;
	logic [3:0] s1_col_off;
	logic [3:0] s1_row_off;
	logic s1_in_grid;
	logic s1_visible;
	logic s1_hsync;
	logic s1_vsync;
	logic [3:0] s2_col_off;
	logic s2_in_grid;
	logic s2_visible;
	logic s2_hsync;
	logic s2_vsync;
	logic pix_on;

	// cell lookup straight from the counters
	always_comb begin
		cell_col = 7'(scan.x / 10'(glyph_w));
		cell_row = 6'(scan.y / 10'(glyph_h));
		// columns 630..639 fall outside the grid
		in_grid = scan.visible && (scan.x < 10'(text_cols * glyph_w));
		text_addr = in_grid ? cell_addr_t'(cell_row * text_cols + cell_col) : '0;
	end

	// glyph address from the returned code and the stage 1 row
	assign glyph_code = text_code;
	assign glyph_row = s1_row_off;

	always_ff @(posedge clk) begin
		s1_col_off <= 4'(scan.x % 10'(glyph_w));
		s1_row_off <= 4'(scan.y % 10'(glyph_h));
		s2_col_off <= s1_col_off;
	end

	// sync and blank pipeline, idles inactive out of reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_in_grid <= 1'b0;
			s1_visible <= 1'b0;
			s1_hsync <= 1'b1;
			s1_vsync <= 1'b1;
			s2_in_grid <= 1'b0;
			s2_visible <= 1'b0;
			s2_hsync <= 1'b1;
			s2_vsync <= 1'b1;
		end else begin
			s1_in_grid <= in_grid;
			s1_visible <= scan.visible;
			s1_hsync <= scan.hsync;
			s1_vsync <= scan.vsync;
			s2_in_grid <= s1_in_grid;
			s2_visible <= s1_visible;
			s2_hsync <= s1_hsync;
			s2_vsync <= s1_vsync;
		end
	end

	assign pix_on = s2_in_grid && glyph_bits[s2_col_off];

	assign vga_hsync = s2_hsync;
	assign vga_vsync = s2_vsync;
	assign vga_blank_n = s2_visible;
	// white on black
	assign vga_r = {8{pix_on}};
	assign vga_g = {8{pix_on}};
	assign vga_b = {8{pix_on}};

endmodule

`default_nettype wire

/* src/text_console.sv */
`default_nettype none
`timescale 1ns/1ps

module text_console (
	input wire clk,
	input wire arst_n,
	input wire char_strobe,
	input wire console_pkg::char_t char_code,
	input wire console_pkg::glyph_wr_t glyph_wr,
	output wire busy,
	output wire vga_hsync,
	output wire vga_vsync,
	output wire vga_blank_n,
	output wire [7:0] vga_r,
	output wire [7:0] vga_g,
	output wire [7:0] vga_b
);

	import console_pkg::*;

	text_wr_t text_wr;
	scan_pos_t scan;
	cell_addr_t text_addr;
	char_t text_code;
	char_t glyph_code;
	logic [3:0] glyph_row;
	glyph_row_t glyph_bits;

	cursor_fsm cursor_i (
		.clk(clk),
		.arst_n(arst_n),
		.char_strobe(char_strobe),
		.char_code(char_code),
		.busy(busy),
		.text_wr(text_wr)
	);

	vga_timing timing_i (
		.clk(clk),
		.arst_n(arst_n),
		.scan(scan)
	);

	text_ram text_ram_i (
		.clk(clk),
		.text_wr(text_wr),
		.rd_addr(text_addr),
		.rd_code(text_code)
	);

	// glyphs are loaded from outside at run time
	glyph_ram glyph_ram_i (
		.clk(clk),
		.glyph_wr(glyph_wr),
		.rd_code(glyph_code),
		.rd_row(glyph_row),
		.rd_bits(glyph_bits)
	);

	glyph_render render_i (
		.clk(clk),
		.arst_n(arst_n),
		.scan(scan),
		.text_addr(text_addr),
		.text_code(text_code),
		.glyph_code(glyph_code),
		.glyph_row(glyph_row),
		.glyph_bits(glyph_bits),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.vga_blank_n(vga_blank_n),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

`default_nettype wire

/* src/text_ram.sv */
`default_nettype none
`timescale 1ns/1ps

module text_ram (
	input wire clk,
	input wire console_pkg::text_wr_t text_wr,
	input wire console_pkg::cell_addr_t rd_addr,
	output console_pkg::char_t rd_code
);

	import console_pkg::*;

	// one byte per text cell
	char_t mem [text_cells];

	always_ff @(posedge clk) begin
		if (text_wr.en) begin
			mem[text_wr.addr] <= text_wr.code;
		end
	end

	// registered read, one cycle of latency
	always_ff @(posedge clk) begin
		rd_code <= mem[rd_addr];
	end

	a_wr_addr: assert property (
		@(posedge clk)
		text_wr.en |-> (text_wr.addr < cell_addr_t'(text_cells))
	);

endmodule

`default_nettype wire

/* src/vga_timing.sv */
`default_nettype none
`timescale 1ns/1ps

module vga_timing (
	input wire clk,
	input wire arst_n,
	output console_pkg::scan_pos_t scan
);

	import console_pkg::*;

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic h_last;
	logic v_last;

	assign h_last = (h_cnt == 10'(h_total - 1));
	assign v_last = (v_cnt == 10'(v_total - 1));

	// pixel counter, steps the line counter at each wrap
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_last) begin
				h_cnt <= '0;
				if (v_last) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 10'd1;
				end
			end else begin
				h_cnt <= h_cnt + 10'd1;
			end
		end
	end

	always_comb begin
		scan.x = h_cnt;
		scan.y = v_cnt;
		scan.visible = (h_cnt < 10'(h_visible)) && (v_cnt < 10'(v_visible));
		// syncs are active low
		scan.hsync = !((h_cnt >= 10'(h_visible + h_front)) &&
			(h_cnt < 10'(h_visible + h_front + h_sync)));
		scan.vsync = !((v_cnt >= 10'(v_visible + v_front)) &&
			(v_cnt < 10'(v_visible + v_front + v_sync)));
	end

	a_h_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		h_cnt < 10'(h_total)
	);

	a_v_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		v_cnt < 10'(v_total)
	);

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic arst_n
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// reset held low for 16 rising edges
	initial begin
		arst_n <= 1'b0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* tests/tb_text_console.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_text_console;

	import console_pkg::*;

	// one table entry, a code sent count times and the cursor expected after it
	typedef struct packed {
		logic [3:0] grp;
		logic [7:0] code;
		logic [6:0] count;
		logic step;
		logic [6:0] col;
		logic [4:0] row;
	} stim_t;

	logic clk;
	logic arst_n;
	logic char_strobe;
	char_t char_code;
	glyph_wr_t glyph_wr;
	wire busy;
	wire vga_hsync;
	wire vga_vsync;
	wire vga_blank_n;
	wire [7:0] vga_r;
	wire [7:0] vga_g;
	wire [7:0] vga_b;

	// reference copies of the text buffer and the glyph store
	char_t text_model [text_cells];
	glyph_row_t glyph_model [256][16];
	int cur_col;
	int cur_row;
	int error_count;
	int tests_passed;
	int tests_failed;
	logic [31:0] rng_state;

	// group, code, count, step code, expected col, expected row
	stim_t stim_table [14] = '{
		'{4'd3, 8'h48, 7'd1, 1'b0, 7'd1, 5'd0},
		'{4'd3, 8'h69, 7'd1, 1'b0, 7'd2, 5'd0},
		'{4'd3, 8'h21, 7'd1, 1'b0, 7'd3, 5'd0},
		'{4'd3, 8'h08, 7'd1, 1'b0, 7'd2, 5'd0},
		'{4'd3, 8'h6F, 7'd1, 1'b0, 7'd3, 5'd0},
		'{4'd3, 8'h0A, 7'd1, 1'b0, 7'd0, 5'd1},
		'{4'd3, 8'h6F, 7'd1, 1'b0, 7'd1, 5'd1},
		'{4'd3, 8'h6B, 7'd1, 1'b0, 7'd2, 5'd1},
		'{4'd4, 8'h0C, 7'd1, 1'b0, 7'd0, 5'd0},
		'{4'd4, 8'h21, 7'd75, 1'b1, 7'd5, 5'd1},
		'{4'd5, 8'h0A, 7'd31, 1'b0, 7'd0, 5'd2},
		'{4'd6, 8'h78, 7'd3, 1'b0, 7'd3, 5'd2},
		'{4'd6, 8'h0C, 7'd1, 1'b0, 7'd0, 5'd0},
		'{4'd7, 8'h40, 7'd1, 1'b0, 7'd1, 5'd0}
	};

	tb_clock clock_i (
		.clk(clk),
		.arst_n(arst_n)
	);

	text_console dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.char_strobe(char_strobe),
		.char_code(char_code),
		.glyph_wr(glyph_wr),
		.busy(busy),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.vga_blank_n(vga_blank_n),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// white where the glyph bit is set, black beyond column 630
	function automatic logic [23:0] expected_rgb(input int x, input int y);
		char_t code;
		glyph_row_t row_bits;
		if (x >= text_cols * glyph_w) begin
			return 24'h0;
		end
		code = text_model[(y / glyph_h) * text_cols + x / glyph_w];
		row_bits = glyph_model[code][y % glyph_h];
		return row_bits[x % glyph_w] ? 24'hffffff : 24'h0;
	endfunction

	task automatic drive_idle_inputs();
		char_strobe <= 1'b0;
		char_code <= '0;
		glyph_wr <= '0;
	endtask

	task automatic load_glyphs();
		glyph_row_t bits;
		for (int c = 0; c < 256; c++) begin
			for (int r = 0; r < glyph_h; r++) begin
				rng_state = xorshift32(rng_state);
				// the space glyph stays blank
				bits = (c == 32'h20) ? '0 : rng_state[8:0];
				glyph_model[c][r] = bits;
				@(posedge clk);
				glyph_wr <= '{en: 1'b1, code: char_t'(c), row: 4'(r), bits: bits};
			end
		end
		@(posedge clk);
		glyph_wr <= '0;
	endtask

	task automatic clear_model();
		for (int i = 0; i < text_cells; i++) begin
			text_model[i] = 8'h20;
		end
		cur_col = 0;
		cur_row = 0;
	endtask

	task automatic apply_to_model(input char_t code, output int busy_exp);
		busy_exp = 1;
		case (code)
			8'h0C: begin
				clear_model();
				busy_exp = text_cells;
			end
			8'h0A: begin
				cur_col = 0;
				if (cur_row < text_rows - 1) begin
					cur_row++;
				end else begin
					clear_model();
					busy_exp += text_cells;
				end
			end
			8'h08: begin
				if (cur_col > 0) begin
					cur_col--;
				end else if (cur_row > 0) begin
					cur_col = text_cols - 1;
					cur_row--;
				end
				text_model[cur_row * text_cols + cur_col] = 8'h20;
			end
			default: begin
				text_model[cur_row * text_cols + cur_col] = code;
				if (cur_col < text_cols - 1) begin
					cur_col++;
				end else if (cur_row < text_rows - 1) begin
					cur_col = 0;
					cur_row++;
				end else begin
					clear_model();
					busy_exp += text_cells;
				end
			end
		endcase
	endtask

	task automatic send_code(input char_t code);
		int busy_exp;
		int n;
		n = 0;
		@(negedge clk);
		while (busy && n < 2 * text_cells + 16) begin
			n++;
			@(negedge clk);
		end
		if (busy) begin
			$display("busy stayed high, code %h could not be sent", code);
			error_count++;
		end
		@(posedge clk);
		char_strobe <= 1'b1;
		char_code <= code;
		@(posedge clk);
		char_strobe <= 1'b0;
		apply_to_model(code, busy_exp);
		n = 0;
		@(negedge clk);
		while (busy && n < 2 * text_cells + 16) begin
			n++;
			@(negedge clk);
		end
		if (n != busy_exp) begin
			$display("[ERROR] %0t: code %h held busy for %0d cycles, expected %0d",
				$time, code, n, busy_exp);
			error_count++;
		end
	endtask

	task automatic send_group(input int grp);
		char_t code;
		int exp_col;
		int exp_row;
		int dut_col;
		int dut_row;
		for (int i = 0; i < 14; i++) begin
			if (int'(stim_table[i].grp) == grp) begin
				for (int k = 0; k < int'(stim_table[i].count); k++) begin
					code = stim_table[i].code;
					if (stim_table[i].step) begin
						code = char_t'(int'(stim_table[i].code) + k);
					end
					send_code(code);
				end
				exp_col = int'(stim_table[i].col);
				exp_row = int'(stim_table[i].row);
				// cursor of the DUT, read while it idles
				dut_col = int'(dut_i.cursor_i.col);
				dut_row = int'(dut_i.cursor_i.row);
				if (dut_col != exp_col || dut_row != exp_row ||
					cur_col != exp_col || cur_row != exp_row) begin
					$display("[ERROR] %0t: code %h cursor (%0d,%0d) model (%0d,%0d) table (%0d,%0d)",
						$time, stim_table[i].code, dut_col, dut_row,
						cur_col, cur_row, exp_col, exp_row);
					error_count++;
				end
			end
		end
	endtask

	task automatic wait_sync_fall(input logic vertical);
		logic prev;
		logic cur;
		int n;
		n = 0;
		@(negedge clk);
		cur = vertical ? vga_vsync : vga_hsync;
		prev = cur;
		while (!(prev && !cur) && n < 2 * h_total * v_total) begin
			@(negedge clk);
			prev = cur;
			cur = vertical ? vga_vsync : vga_hsync;
			n++;
		end
		if (!(prev && !cur)) begin
			$display("sync pulse never started within two frames (vertical=%b)", vertical);
			error_count++;
		end
	endtask

	// called right after a vsync fall, compares the next 480 visible lines
	task automatic check_frame();
		int x;
		int y;
		int bad;
		logic prev_blank;
		logic [23:0] got;
		logic [23:0] exp;
		x = 0;
		y = 0;
		bad = 0;
		prev_blank = 1'b0;
		while (y < v_visible) begin
			@(negedge clk);
			if (vga_blank_n) begin
				got = {vga_r, vga_g, vga_b};
				exp = expected_rgb(x, y);
				if (got !== exp) begin
					bad++;
					if (bad <= 8) begin
						$display("[ERROR] %0t: pixel (%0d,%0d) is %h, expected %h",
							$time, x, y, got, exp);
					end
				end
				x++;
			end else if (prev_blank) begin
				x = 0;
				y++;
			end
			prev_blank = vga_blank_n;
		end
		if (bad > 8) begin
			$display("[ERROR] %0t: %0d pixels in this frame differ", $time, bad);
		end
		error_count += bad;
	endtask

	task automatic check_reset();
		int n;
		repeat (4) @(negedge clk);
		if (!busy || !vga_hsync || !vga_vsync || vga_blank_n) begin
			$display("[ERROR] %0t: in reset busy=%b hsync=%b vsync=%b blank_n=%b",
				$time, busy, vga_hsync, vga_vsync, vga_blank_n);
			error_count++;
		end
		if ({vga_r, vga_g, vga_b} !== 24'h0) begin
			$display("[ERROR] %0t: rgb is %h in reset", $time, {vga_r, vga_g, vga_b});
			error_count++;
		end
		wait (arst_n == 1'b1);
		n = 0;
		@(negedge clk);
		while (busy && n < text_cells + 64) begin
			n++;
			@(negedge clk);
		end
		if (busy) begin
			$display("busy never fell after the power-up clear");
			error_count++;
		end else if (n < text_cells || n > text_cells + 4) begin
			$display("[ERROR] %0t: power-up clear took %0d cycles", $time, n);
			error_count++;
		end
	endtask

	task automatic check_video_timing();
		int low_w;
		int period;
		int lines;
		int px;
		int bad_lines;
		logic prev_blank;
		wait_sync_fall(1'b0);
		low_w = 0;
		period = 0;
		while (!vga_hsync && period < 2 * h_total) begin
			low_w++;
			period++;
			@(negedge clk);
		end
		while (vga_hsync && period < 2 * h_total) begin
			period++;
			@(negedge clk);
		end
		if (low_w != h_sync || period != h_total) begin
			$display("[ERROR] %0t: hsync low %0d of %0d cycles", $time, low_w, period);
			error_count++;
		end
		wait_sync_fall(1'b1);
		low_w = 0;
		period = 0;
		lines = 0;
		px = 0;
		bad_lines = 0;
		prev_blank = 1'b0;
		while (!vga_vsync && period < 2 * h_total * v_total) begin
			low_w++;
			period++;
			@(negedge clk);
		end
		// the whole visible area lies between two vsync pulses
		while (vga_vsync && period < 2 * h_total * v_total) begin
			if (vga_blank_n) begin
				px++;
			end else if (prev_blank) begin
				lines++;
				if (px != h_visible) begin
					bad_lines++;
				end
				px = 0;
			end
			prev_blank = vga_blank_n;
			period++;
			@(negedge clk);
		end
		if (low_w != v_sync * h_total || period != v_total * h_total) begin
			$display("[ERROR] %0t: vsync low %0d of %0d cycles", $time, low_w, period);
			error_count++;
		end
		if (lines != v_visible || bad_lines != 0) begin
			$display("[ERROR] %0t: %0d visible lines, %0d of wrong width",
				$time, lines, bad_lines);
			error_count++;
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, error_count - errors_before);
		end
	endtask

	initial begin
		int errors_before;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		rng_state = 32'h0a63c57c;
		drive_idle_inputs();

		errors_before = error_count;
		check_reset();
		load_glyphs();
		clear_model();
		wait_sync_fall(1'b1);
		check_frame();
		end_test("reset", errors_before);

		errors_before = error_count;
		check_video_timing();
		end_test("video timing", errors_before);

		errors_before = error_count;
		send_group(3);
		wait_sync_fall(1'b1);
		check_frame();
		end_test("printing", errors_before);

		errors_before = error_count;
		send_group(4);
		wait_sync_fall(1'b1);
		check_frame();
		end_test("line wrap", errors_before);

		// wrap by newlines, then form feed, then a character at home
		errors_before = error_count;
		send_group(5);
		wait_sync_fall(1'b1);
		check_frame();
		send_group(6);
		wait_sync_fall(1'b1);
		check_frame();
		send_group(7);
		wait_sync_fall(1'b1);
		check_frame();
		end_test("clearing", errors_before);

		$display("%0d tests: %0d ok, %0d failing, %0d errors",
			tests_passed + tests_failed, tests_passed, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		int limit;
		// ten frames, four clear sweeps and the glyph load
		limit = 10 * h_total * v_total + 4 * text_cells + 256 * glyph_h + 64;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d clock cycles, the run did not finish", limit);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
